//--- core_pkg.sv
package core_pkg;

	localparam int XLEN        = 32;	// Data word width
	localparam int REG_ADDR_W  = 5;
	localparam int PC_W        = 12;	// Instruction address width
	localparam int DMEM_ADDR_W = 10;	// Word address into data memory
	localparam int DMEM_WORDS  = 1024;

	typedef logic [XLEN-1:0]        word_t;
	typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
	typedef logic [PC_W-1:0]        pc_t;
	typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

	// Major opcodes of the kept RV32I subset
	localparam logic [6:0] OP_REG   = 7'b0110011;
	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_LUI   = 7'b0110111;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	// Operand source in ID
	typedef enum logic [1:0] {
		FWD_RF, FWD_EXE, FWD_MEM, FWD_WB
	} fwd_sel_e;

	localparam word_t NOP_INST = 32'h0000_0013;	// addi x0, x0, 0

endpackage

//--- alu.sv
`timescale 1ns/1ns

module alu(
	input  core_pkg::word_t   op_a,
	input  core_pkg::word_t   op_b,
	input  core_pkg::alu_op_e alu_op,
	output core_pkg::word_t   res
);
	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = op_b[4:0];				// Shift amount from low bits only

	always_comb begin
		case (alu_op)
			ALU_ADD:  res = op_a + op_b;
			ALU_SUB:  res = op_a - op_b;
			ALU_SLL:  res = op_a << shamt;
			ALU_SLT:  res = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU: res = word_t'(op_a < op_b);
			ALU_XOR:  res = op_a ^ op_b;
			ALU_SRL:  res = op_a >> shamt;
			ALU_SRA:  res = $signed(op_a) >>> shamt;	// Sign fill
			ALU_OR:   res = op_a | op_b;
			ALU_AND:  res = op_a & op_b;
			default:  res = '0;
		endcase
	end

endmodule

//--- regfile.sv
`timescale 1ns/1ns

module regfile(
	input  logic                CLK,
	input  logic                rst_n,
	input  core_pkg::reg_addr_t rs1,
	input  core_pkg::reg_addr_t rs2,
	output core_pkg::word_t     rs1_data,
	output core_pkg::word_t     rs2_data,
	input  logic                wr_en,
	input  core_pkg::reg_addr_t wr_addr,
	input  core_pkg::word_t     wr_data
);
	import core_pkg::*;

	word_t regs [0:(1 << REG_ADDR_W)-1];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << REG_ADDR_W); i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin	// x0 stays zero
			regs[wr_addr] <= wr_data;
		end
	end

	// No write-through, WB forwarding covers it
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

endmodule

//--- decoder.sv
`timescale 1ns/1ns

module decoder(
	input  core_pkg::word_t     inst,
	input  logic                valid,
	output core_pkg::reg_addr_t rs1,
	output core_pkg::reg_addr_t rs2,
	output core_pkg::reg_addr_t rd,
	output core_pkg::word_t     imm,
	output core_pkg::alu_op_e   alu_op,
	output logic                use_imm,	// Operand B is the immediate
	output logic                zero_a,		// Operand A forced to zero
	output logic                wr_en,
	output logic                is_load,
	output logic                is_store
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic funct7_b5;						// SUB and SRA select
	reg_addr_t f_rs1, f_rs2, f_rd;
	word_t imm_i, imm_s, imm_u;
	alu_op_e f3_op;

	assign opcode    = inst[6:0];
	assign f_rd      = inst[11:7];
	assign funct3    = inst[14:12];
	assign f_rs1     = inst[19:15];
	assign f_rs2     = inst[24:20];
	assign funct7_b5 = inst[30];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};

	// ALU function from funct3
	always_comb begin
		case (funct3)
			3'b000:  f3_op = (opcode == OP_REG && funct7_b5) ? ALU_SUB : ALU_ADD;	// No SUBI
			3'b001:  f3_op = ALU_SLL;
			3'b010:  f3_op = ALU_SLT;
			3'b011:  f3_op = ALU_SLTU;
			3'b100:  f3_op = ALU_XOR;
			3'b101:  f3_op = funct7_b5 ? ALU_SRA : ALU_SRL;
			3'b110:  f3_op = ALU_OR;
			default: f3_op = ALU_AND;
		endcase
	end

	// Unused sources stay x0 so they never match a hazard
	always_comb begin
		rs1 = '0; rs2 = '0; rd = '0; imm = '0;
		alu_op = ALU_ADD;
		use_imm = 1'b0; zero_a = 1'b0;
		wr_en = 1'b0; is_load = 1'b0; is_store = 1'b0;
		if (valid) begin
			case (opcode)
				OP_REG: begin
					rs1 = f_rs1; rs2 = f_rs2; rd = f_rd;
					alu_op = f3_op; wr_en = 1'b1;
				end
				OP_IMM: begin
					rs1 = f_rs1; rd = f_rd; imm = imm_i;
					alu_op = f3_op; use_imm = 1'b1; wr_en = 1'b1;
				end
				OP_LUI: begin
					rd = f_rd; imm = imm_u;		// 0 + imm
					use_imm = 1'b1; zero_a = 1'b1; wr_en = 1'b1;
				end
				OP_LOAD: if (funct3 == 3'b010) begin	// LW only
					rs1 = f_rs1; rd = f_rd; imm = imm_i;
					use_imm = 1'b1; wr_en = 1'b1; is_load = 1'b1;
				end
				OP_STORE: if (funct3 == 3'b010) begin	// SW only
					rs1 = f_rs1; rs2 = f_rs2; imm = imm_s;
					use_imm = 1'b1; is_store = 1'b1;
				end
				default: ;							// Unknown, stays a nop
			endcase
		end
	end

endmodule

//--- forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit(
	input  logic                id_valid,
	input  core_pkg::reg_addr_t id_rs1,
	input  core_pkg::reg_addr_t id_rs2,
	input  logic                id_use_imm,
	input  logic                id_zero_a,
	input  core_pkg::word_t     id_imm,
	input  core_pkg::word_t     rs1_data,
	input  core_pkg::word_t     rs2_data,
	input  core_pkg::reg_addr_t exe_rd,
	input  logic                exe_wr_en,
	input  logic                exe_is_load,
	input  core_pkg::word_t     exe_result,
	input  core_pkg::reg_addr_t mem_rd,
	input  logic                mem_wr_en,
	input  core_pkg::word_t     mem_result,		// Load data once in MEM
	input  core_pkg::reg_addr_t wb_rd,
	input  logic                wb_wr_en,
	input  core_pkg::word_t     wb_data,
	output core_pkg::word_t     op_a,
	output core_pkg::word_t     op_b,
	output core_pkg::word_t     store_data,
	output logic                stall
);
	import core_pkg::*;

	fwd_sel_e sel_a, sel_b;
	word_t rs1_val, rs2_val;

	// Newest producer wins, x0 never forwarded
	function automatic fwd_sel_e pick_src(input reg_addr_t rs);
		if (rs == '0)
			return FWD_RF;
		else if (exe_wr_en && exe_rd == rs)
			return FWD_EXE;
		else if (mem_wr_en && mem_rd == rs)
			return FWD_MEM;
		else if (wb_wr_en && wb_rd == rs)
			return FWD_WB;
		return FWD_RF;
	endfunction

	// Re-evaluated on any stage destination change as well
	always_comb begin
		sel_a = pick_src(id_rs1);
		sel_b = pick_src(id_rs2);
	end

	always_comb begin
		case (sel_a)
			FWD_EXE: rs1_val = exe_result;
			FWD_MEM: rs1_val = mem_result;
			FWD_WB:  rs1_val = wb_data;
			default: rs1_val = rs1_data;
		endcase
		case (sel_b)
			FWD_EXE: rs2_val = exe_result;
			FWD_MEM: rs2_val = mem_result;
			FWD_WB:  rs2_val = wb_data;
			default: rs2_val = rs2_data;
		endcase
	end

	assign op_a       = id_zero_a ? '0 : rs1_val;	// LUI
	assign op_b       = id_use_imm ? id_imm : rs2_val;
	assign store_data = rs2_val;					// SW data, separate from op_b

	// Load result not ready until MEM, hold ID one cycle
	assign stall = id_valid && exe_is_load && exe_wr_en && exe_rd != '0 &&
		(exe_rd == id_rs1 || exe_rd == id_rs2);

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage(
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                bubble,		// Insert a nop into EXE
	input  core_pkg::word_t     id_op_a,
	input  core_pkg::word_t     id_op_b,
	input  core_pkg::word_t     id_store_data,
	input  core_pkg::reg_addr_t id_rd,
	input  core_pkg::alu_op_e   id_alu_op,
	input  logic                id_wr_en,
	input  logic                id_is_load,
	input  logic                id_is_store,
	output core_pkg::reg_addr_t exe_rd,
	output logic                exe_wr_en,
	output logic                exe_is_load,
	output logic                exe_is_store,
	output core_pkg::word_t     exe_result,
	output core_pkg::word_t     exe_store_data
);
	import core_pkg::*;

	word_t op_a_q, op_b_q;
	alu_op_e alu_op_q;

	// ID/EXE register
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			op_a_q         <= '0;
			op_b_q         <= '0;
			exe_store_data <= '0;
			alu_op_q       <= ALU_ADD;
			exe_rd         <= '0;
			exe_wr_en      <= 1'b0;
			exe_is_load    <= 1'b0;
			exe_is_store   <= 1'b0;
		end else begin
			op_a_q         <= id_op_a;
			op_b_q         <= id_op_b;
			exe_store_data <= id_store_data;
			alu_op_q       <= id_alu_op;
			exe_rd         <= bubble ? '0 : id_rd;
			exe_wr_en      <= id_wr_en && !bubble;		// Bubble kills all enables
			exe_is_load    <= id_is_load && !bubble;
			exe_is_store   <= id_is_store && !bubble;
		end
	end

	alu u_alu (
		.op_a(op_a_q),
		.op_b(op_b_q),
		.alu_op(alu_op_q),
		.res(exe_result)				// Also the memory byte address
	);

endmodule

//--- mem_stage.sv
`timescale 1ns/1ns

module mem_stage(
	input  logic                 CLK,
	input  logic                 rst_n,
	input  core_pkg::reg_addr_t  exe_rd,
	input  logic                 exe_wr_en,
	input  logic                 exe_is_load,
	input  logic                 exe_is_store,
	input  core_pkg::word_t      exe_result,
	input  core_pkg::word_t      exe_store_data,
	input  logic                 con_write,
	input  core_pkg::dmem_addr_t con_addr,
	input  core_pkg::word_t      con_in,
	output core_pkg::word_t      con_out,
	output core_pkg::reg_addr_t  mem_rd,
	output logic                 mem_wr_en,
	output core_pkg::word_t      mem_result,
	output core_pkg::reg_addr_t  wb_rd,
	output logic                 wb_wr_en,
	output core_pkg::word_t      wb_data
);
	import core_pkg::*;

	word_t dmem [0:DMEM_WORDS-1];
	dmem_addr_t core_addr;
	word_t load_data;						// Read with the EXE address
	word_t con_rd;
	word_t mem_alu;
	logic mem_is_load;

	assign core_addr = exe_result[DMEM_ADDR_W+1:2];	// Word index of byte address

	// Two ports, core store beats protocol write
	always_ff @(posedge CLK) begin
		if (exe_is_store)
			dmem[core_addr] <= exe_store_data;
		else if (con_write)
			dmem[con_addr] <= con_in;
		load_data <= dmem[core_addr];
		con_rd    <= dmem[con_addr];		// One cycle latency
	end

	assign con_out = con_rd;

	// EXE/MEM register
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mem_rd      <= '0;
			mem_wr_en   <= 1'b0;
			mem_is_load <= 1'b0;
			mem_alu     <= '0;
		end else begin
			mem_rd      <= exe_rd;
			mem_wr_en   <= exe_wr_en;
			mem_is_load <= exe_is_load;
			mem_alu     <= exe_result;
		end
	end

	// Result select, also the MEM forwarding source
	assign mem_result = mem_is_load ? load_data : mem_alu;

	// MEM/WB register
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_rd    <= '0;
			wb_wr_en <= 1'b0;
			wb_data  <= '0;
		end else begin
			wb_rd    <= mem_rd;
			wb_wr_en <= mem_wr_en;
			wb_data  <= mem_result;
		end
	end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit(
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              stall,		// Hold IF/ID, ignore ack

	output logic              inst_req,
	output core_pkg::pc_t     inst_addr,
	input  logic              inst_ack,
	input  core_pkg::word_t   inst_data,

	output core_pkg::word_t   id_inst,
	output logic              id_valid
);
	import core_pkg::*;

	pc_t pc;
	logic capture;

	// Instruction taken on this edge
	assign capture = inst_req && inst_ack && !stall;
	assign inst_addr = pc;					// Stable for the whole request

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			inst_req <= 1'b0;
			pc       <= '0;
			id_inst  <= NOP_INST;
			id_valid <= 1'b0;
		end else begin
			// Handshake and PC
			if (capture) begin
				inst_req <= 1'b0;
				pc       <= pc + pc_t'(4);
			end else if (!inst_req && !inst_ack) begin
				inst_req <= 1'b1;			// Responder idle again, next request
			end

			// IF/ID register
			if (capture) begin
				id_inst  <= inst_data;
				id_valid <= 1'b1;
			end else if (!stall) begin
				id_inst  <= NOP_INST;		// Slot moved on, nothing new
				id_valid <= 1'b0;
			end
		end
	end

endmodule

//--- core.sv
`timescale 1ns/1ns

module core(
	input  logic                    CLK,
	input  logic                    rst_n,

	// Instruction fetch port, four-phase
	output logic                    inst_req,
	output core_pkg::pc_t           inst_addr,
	input  logic                    inst_ack,
	input  core_pkg::word_t         inst_data,

	// Protocol controller port into data memory
	input  logic                    con_write,
	input  core_pkg::dmem_addr_t    con_addr,
	input  core_pkg::word_t         con_in,
	output core_pkg::word_t         con_out
);
	import core_pkg::*;

	// ID stage
	word_t id_inst, id_imm, id_rs1_data, id_rs2_data;
	logic id_valid, id_use_imm, id_zero_a, id_wr_en, id_is_load, id_is_store;
	reg_addr_t id_rs1, id_rs2, id_rd;
	alu_op_e id_alu_op;
	word_t id_op_a, id_op_b, id_store_data;	// Operands after forwarding
	logic stall;							// Load-use hazard

	// EXE stage
	reg_addr_t exe_rd;
	logic exe_wr_en, exe_is_load, exe_is_store;
	word_t exe_result, exe_store_data;

	// MEM and WB stages
	reg_addr_t mem_rd, wb_rd;
	logic mem_wr_en, wb_wr_en;
	word_t mem_result, wb_data;

	fetch_unit u_fetch (.CLK, .rst_n, .stall, .inst_req, .inst_addr, .inst_ack, .inst_data,
		.id_inst, .id_valid);

	decoder u_dec (.inst(id_inst), .valid(id_valid), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd),
		.imm(id_imm), .alu_op(id_alu_op), .use_imm(id_use_imm), .zero_a(id_zero_a),
		.wr_en(id_wr_en), .is_load(id_is_load), .is_store(id_is_store));

	regfile u_rf (.CLK, .rst_n, .rs1(id_rs1), .rs2(id_rs2), .rs1_data(id_rs1_data),
		.rs2_data(id_rs2_data), .wr_en(wb_wr_en), .wr_addr(wb_rd), .wr_data(wb_data));

	forwarding_unit u_fwd (.id_valid, .id_rs1, .id_rs2, .id_use_imm, .id_zero_a, .id_imm,
		.rs1_data(id_rs1_data), .rs2_data(id_rs2_data),
		.exe_rd, .exe_wr_en, .exe_is_load, .exe_result,
		.mem_rd, .mem_wr_en, .mem_result, .wb_rd, .wb_wr_en, .wb_data,
		.op_a(id_op_a), .op_b(id_op_b), .store_data(id_store_data), .stall);

	execute_stage u_exe (.CLK, .rst_n, .bubble(stall), .id_op_a, .id_op_b, .id_store_data,
		.id_rd, .id_alu_op, .id_wr_en, .id_is_load, .id_is_store,
		.exe_rd, .exe_wr_en, .exe_is_load, .exe_is_store, .exe_result, .exe_store_data);

	mem_stage u_mem (.CLK, .rst_n, .exe_rd, .exe_wr_en, .exe_is_load, .exe_is_store,
		.exe_result, .exe_store_data, .con_write, .con_addr, .con_in, .con_out,
		.mem_rd, .mem_wr_en, .mem_result, .wb_rd, .wb_wr_en, .wb_data);

endmodule

//--- tb_core.sv
`timescale 1ns/1ns

module tb_core;
	import core_pkg::*;

	localparam int SEED            = 12060;
	localparam int PROG_LEN        = 200;
	localparam int FINAL_STORES    = 31;			// SW x1..x31 at the end
	localparam int RAND_LEN        = PROG_LEN - FINAL_STORES;
	localparam int PRELOAD_WORDS   = 256;
	localparam int RESULT_BASE     = 512;			// Register dump area
	localparam int DRAIN_CYCLES    = 20;
	localparam int TIMEOUT_CYCLES  = 256 + PROG_LEN * 8 + 600 + 200;

	logic CLK = 1'b0;
	logic rst_n;
	logic inst_req;
	pc_t inst_addr;
	logic inst_ack = 1'b0;
	word_t inst_data = NOP_INST;
	logic con_write;
	dmem_addr_t con_addr;
	word_t con_in;
	word_t con_out;

	word_t prog [0:PROG_LEN-1];
	word_t model_regs [0:31];
	word_t model_mem [0:DMEM_WORDS-1];
	word_t rd_buf [0:PRELOAD_WORDS-1];				// Words from the last read_back

	logic prog_go = 1'b0;							// Responder gate, opens after preload
	logic resp_busy = 1'b0;
	int resp_delay = 0;
	logic reset_seen = 1'b0;
	logic prev_req = 1'b0;
	logic prev_ack = 1'b0;
	pc_t prev_addr = '0;
	pc_t next_addr = '0;							// Expected address of the next request
	int fetch_count = 0;
	int cycles = 0;

	core core_i (.CLK, .rst_n, .inst_req, .inst_addr, .inst_ack, .inst_data,
		.con_write, .con_addr, .con_in, .con_out);

	always #2 CLK = ~CLK;

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic check_addr(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic protocol_error(input string what);
		$display("Fetch handshake broken at t=%0t: %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	function automatic reg_addr_t pick_reg();
		return reg_addr_t'($urandom % 8);			// x0..x7, dense dependencies
	endfunction

	// Random ALU, LUI, LW and SW mix, then the register dump
	task automatic gen_program();
		int kind;
		reg_addr_t rd, rs1, rs2;
		logic [2:0] f3;
		logic alt;
		logic [11:0] imm12, off;
		for (int i = 0; i < RAND_LEN; i++) begin
			kind = $urandom % 100;
			rd = pick_reg();
			rs1 = pick_reg();
			rs2 = pick_reg();
			f3 = 3'($urandom % 8);
			off = 12'(($urandom % PRELOAD_WORDS) * 4);	// Word 0..255, base x0
			if (kind < 30) begin
				alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1);
				prog[i] = {(alt ? 7'b0100000 : 7'b0000000), rs2, rs1, f3, rd, OP_REG};
			end else if (kind < 55) begin
				if (f3 == 3'd1 || f3 == 3'd5)
					imm12 = {((f3 == 3'd5 && $urandom % 2 == 1) ? 7'b0100000 : 7'b0000000),
						5'($urandom)};				// Shift amount form
				else
					imm12 = 12'($urandom);
				prog[i] = {imm12, rs1, f3, rd, OP_IMM};
			end else if (kind < 65) begin
				prog[i] = {20'($urandom), rd, OP_LUI};
			end else if (kind < 85) begin
				prog[i] = {off, 5'd0, 3'b010, rd, OP_LOAD};
			end else begin
				prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], OP_STORE};
			end
		end
		// Offset wraps negative, bits 11:2 still land on word 512 and up
		for (int k = 1; k <= FINAL_STORES; k++) begin
			off = 12'(RESULT_BASE * 4 + (k - 1) * 4);
			prog[RAND_LEN + k - 1] = {off[11:5], reg_addr_t'(k), 5'd0, 3'b010, off[4:0], OP_STORE};
		end
		for (int i = 0; i < PRELOAD_WORDS; i++)
			model_mem[i] = $urandom;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
	endtask

	function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		word_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = $signed(a) >>> b[4:0];		// Arithmetic
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// In-order architectural model, one instruction at a time
	task automatic run_model();
		word_t inst, res, addr;
		reg_addr_t rd, rs1, rs2;
		logic [2:0] f3;
		logic wr;
		for (int pc = 0; pc < PROG_LEN; pc++) begin
			inst = prog[pc];
			rd = inst[11:7];
			f3 = inst[14:12];
			rs1 = inst[19:15];
			rs2 = inst[24:20];
			wr = 1'b1;
			res = '0;
			case (inst[6:0])
				OP_REG: res = ref_alu(f3, inst[30], model_regs[rs1], model_regs[rs2]);
				OP_IMM: res = ref_alu(f3, f3 == 3'd5 && inst[30], model_regs[rs1],
					{{20{inst[31]}}, inst[31:20]});
				OP_LUI: res = {inst[31:12], 12'b0};
				OP_LOAD: begin
					addr = model_regs[rs1] + {{20{inst[31]}}, inst[31:20]};
					res = model_mem[addr[11:2]];
				end
				default: begin						// SW, the only other kind generated
					addr = model_regs[rs1] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
					model_mem[addr[11:2]] = model_regs[rs2];
					wr = 1'b0;
				end
			endcase
			if (wr && rd != '0)
				model_regs[rd] = res;				// x0 writes dropped
		end
	endtask

	function automatic word_t fetch_word(input pc_t addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < PROG_LEN)
			return prog[idx];
		return NOP_INST;							// Past the end
	endfunction

	// Pipelined protocol-port reads, data two edges after the address
	task automatic read_back(input int base, input int count);
		for (int i = 0; i < count + 2; i++) begin
			@(posedge CLK);
			if (i >= 2)
				rd_buf[i-2] = con_out;
			if (i < count)
				con_addr <= dmem_addr_t'(base + i);
		end
	endtask

	// Fetch responder, random 0..3 cycle wait before each ack
	always @(posedge CLK) begin
		if (!rst_n) begin
			inst_ack <= 1'b0;
			resp_busy = 1'b0;
		end else if (inst_ack) begin
			if (!inst_req)
				inst_ack <= 1'b0;					// Core took it, close the cycle
		end else if (inst_req && prog_go) begin
			if (!resp_busy) begin
				resp_busy = 1'b1;
				resp_delay = $urandom % 4;
			end
			if (resp_delay == 0) begin
				inst_ack <= 1'b1;
				inst_data <= fetch_word(inst_addr);
				resp_busy = 1'b0;
			end else begin
				resp_delay = resp_delay - 1;
			end
		end
	end

	// Handshake monitor
	always @(posedge CLK) begin
		if (!rst_n) begin
			if (reset_seen && inst_req !== 1'b0)
				protocol_error("inst_req is high while reset is still asserted");
			reset_seen <= 1'b1;
			prev_req <= 1'b0;
			prev_ack <= 1'b0;
		end else begin
			if (prev_req && inst_req && inst_addr != prev_addr)
				protocol_error("inst_addr changed while inst_req was high");
			if (prev_req && !inst_req && !prev_ack)
				protocol_error("inst_req dropped before inst_ack was raised");
			if (!prev_req && inst_req && prev_ack)
				protocol_error("inst_req rose while inst_ack was still high");
			if (!prev_req && inst_req) begin
				check_addr("inst_addr", inst_addr, next_addr);
				next_addr <= next_addr + pc_t'(4);
			end
			if (prev_req && !inst_req)
				fetch_count <= fetch_count + 1;	// One capture per falling req
			prev_req <= inst_req;
			prev_ack <= inst_ack;
			prev_addr <= inst_addr;
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		con_write = 1'b0;
		con_addr = '0;
		con_in = '0;
		gen_program();
		repeat (5) @(posedge CLK);
		rst_n <= 1'b1;
		for (int i = 0; i < PRELOAD_WORDS; i++) begin
			@(posedge CLK);
			con_write <= 1'b1;
			con_addr <= dmem_addr_t'(i);
			con_in <= model_mem[i];
		end
		@(posedge CLK);
		con_write <= 1'b0;
		read_back(0, PRELOAD_WORDS);
		for (int i = 0; i < PRELOAD_WORDS; i++)
			check_word($sformatf("con_out[%0d]", i), rd_buf[i], model_mem[i]);
		run_model();
		@(posedge CLK);
		prog_go <= 1'b1;
		while (fetch_count < PROG_LEN)
			@(posedge CLK);
		repeat (DRAIN_CYCLES) @(posedge CLK);	// Last stores leave the pipeline
		read_back(RESULT_BASE, FINAL_STORES);
		for (int k = 1; k <= FINAL_STORES; k++)
			check_word($sformatf("x%0d", k), rd_buf[k-1], model_regs[k]);
		read_back(0, PRELOAD_WORDS);
		for (int i = 0; i < PRELOAD_WORDS; i++)
			check_word($sformatf("dmem[%0d]", i), rd_buf[i], model_mem[i]);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- compile.f
core_pkg.sv
alu.sv
regfile.sv
decoder.sv
forwarding_unit.sv
execute_stage.sv
mem_stage.sv
fetch_unit.sv
core.sv
tb_core.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing -j 0 --top-module tb_core -Mdir obj_dir -f compile.f; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qx "CHECKS FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation passed"
exit 0
